// ==== Makefile ====
# Verilator build and run of the data MMU testbench
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vdmmu_tb: flist.f $(SRCS)
	verilator --binary --timing --top-module dmmu_tb -f flist.f -o Vdmmu_tb

run: obj_dir/Vdmmu_tb
	./obj_dir/Vdmmu_tb

clean:
	rm -rf obj_dir

// ==== flist.f ====
hdl/dmmu_pkg.sv
hdl/tlb_ram.sv
hdl/dmmu_spr_decode.sv
hdl/dmmu_lookup.sv
hdl/dmmu_check.sv
hdl/dmmu_top.sv
verification/dmmu_tb.sv

// ==== hdl/dmmu_check.sv ====
/* Physical address, cache inhibit and page fault from the translate entry.
   Fault is reported whether or not the lookup missed */
`timescale 1ns/1ps

module dmmu_check (
   input  logic [dmmu_pkg::operand_width-1:0]   trans_word_i,
   input  logic [dmmu_pkg::operand_width-1:0]   virt_addr_match_i,
   input  logic                                 op_load_i,
   input  logic                                 op_store_i,
   input  logic                                 supervisor_mode_i,
   output logic [dmmu_pkg::operand_width-1:0]   phys_addr_o,
   output logic                                 cache_inhibit_o,
   output logic                                 pagefault_o
);

   localparam int pb = dmmu_pkg::page_bits;
   localparam int ow = dmmu_pkg::operand_width;

   logic ure;      // User read enable
   logic uwe;      // User write enable
   logic sre;      // Supervisor read enable
   logic swe;      // Supervisor write enable
   logic rd_ok;    // Read allowed in current mode
   logic wr_ok;    // Write allowed in current mode

   // PPN joined to the untranslated page offset
   assign phys_addr_o = {trans_word_i[ow-1:pb], virt_addr_match_i[pb-1:0]};

   assign cache_inhibit_o = trans_word_i[dmmu_pkg::tr_ci_bit];

   assign ure = trans_word_i[dmmu_pkg::tr_ure_bit];
   assign uwe = trans_word_i[dmmu_pkg::tr_uwe_bit];
   assign sre = trans_word_i[dmmu_pkg::tr_sre_bit];
   assign swe = trans_word_i[dmmu_pkg::tr_swe_bit];

   // Pick the permission pair for the mode
   assign rd_ok = supervisor_mode_i ? sre : ure;
   assign wr_ok = supervisor_mode_i ? swe : uwe;

   // No operation, no fault
   assign pagefault_o = (op_store_i & ~wr_ok) | (op_load_i & ~rd_ok);

endmodule

// ==== hdl/dmmu_lookup.sv ====
/* Match and translate RAMs with the tag compare. An SPR strobe steals the RAM
   address, so the lookup result in the following cycle is not valid */
`timescale 1ns/1ps

module dmmu_lookup #(
   parameter int set_width = 6
) (
   input  logic                                 clk,
   input  logic [dmmu_pkg::operand_width-1:0]   virt_addr_i,
   input  logic [dmmu_pkg::operand_width-1:0]   virt_addr_match_i,
   input  dmmu_pkg::spr_sel_e                   spr_sel_i,
   input  logic                                 spr_we_i,
   input  logic [set_width-1:0]                 spr_index_i,
   input  logic [dmmu_pkg::operand_width-1:0]   spr_dat_i,
   output logic [dmmu_pkg::operand_width-1:0]   match_word_o,
   output logic [dmmu_pkg::operand_width-1:0]   trans_word_o,
   output logic                                 tlb_miss_o
);

   localparam int pb = dmmu_pkg::page_bits;
   localparam int ow = dmmu_pkg::operand_width;

   logic [set_width-1:0] lookup_index;   // Set from the VPN low bits
   logic [set_width-1:0] match_addr;
   logic [set_width-1:0] trans_addr;
   logic                 match_we;
   logic                 trans_we;
   logic                 vpn_differs;
   logic                 entry_valid;

   assign lookup_index = virt_addr_i[pb +: set_width];

   // SPR access wins the address of the RAM it names
   assign match_addr = (spr_sel_i == dmmu_pkg::SEL_MATCH) ? spr_index_i : lookup_index;
   assign trans_addr = (spr_sel_i == dmmu_pkg::SEL_TRANS) ? spr_index_i : lookup_index;

   assign match_we = (spr_sel_i == dmmu_pkg::SEL_MATCH) & spr_we_i;
   assign trans_we = (spr_sel_i == dmmu_pkg::SEL_TRANS) & spr_we_i;

   // Match entries, VPN in 31..13 plus valid
   tlb_ram #(
      .addr_width (set_width),
      .data_width (ow)
   ) match_ram (
      .clk     (clk),
      .raddr_i (match_addr),
      .waddr_i (match_addr),
      .we_i    (match_we),
      .din_i   (spr_dat_i),
      .dout_o  (match_word_o)
   );

   // Translate entries, PPN in 31..13 plus CI and permissions
   tlb_ram #(
      .addr_width (set_width),
      .data_width (ow)
   ) trans_ram (
      .clk     (clk),
      .raddr_i (trans_addr),
      .waddr_i (trans_addr),
      .we_i    (trans_we),
      .din_i   (spr_dat_i),
      .dout_o  (trans_word_o)
   );

   // Tag compare against the access now in the lookup stage
   assign vpn_differs = match_word_o[ow-1:pb] != virt_addr_match_i[ow-1:pb];
   assign entry_valid = match_word_o[dmmu_pkg::mr_valid_bit];

   assign tlb_miss_o = vpn_differs | ~entry_valid;

endmodule

// ==== hdl/dmmu_pkg.sv ====
/* Shared widths, SPR map and TLB entry layout for the data MMU.
   One way only; pages are 8 KB, so VPN and PPN both sit in bits 31..13 */
package dmmu_pkg;

   // Datapath
   localparam int operand_width = 32;     // Data and address width
   localparam int page_bits     = 13;     // 8 KB page offset

   // SPR group of the data MMU, held in spr_addr[15:11]
   localparam logic [4:0] spr_group_dmmu = 5'd1;

   // Way-0 range bounds
   localparam logic [15:0] spr_dtlbw0mr0_addr = 16'h0A00;  // First match reg
   localparam logic [15:0] spr_dtlbw0tr0_addr = 16'h0A80;  // First translate reg
   localparam logic [15:0] spr_dtlbw1mr0_addr = 16'h0B00;  // End of way 0

   // Match entry
   localparam int mr_valid_bit = 0;

   // Translate entry
   localparam int tr_ci_bit  = 1;         // Cache inhibit
   localparam int tr_ure_bit = 6;         // User read
   localparam int tr_uwe_bit = 7;         // User write
   localparam int tr_sre_bit = 8;         // Supervisor read
   localparam int tr_swe_bit = 9;         // Supervisor write

   // Which TLB RAM an SPR access targets
   typedef enum logic [1:0] {
      SEL_NONE  = 2'd0,
      SEL_MATCH = 2'd1,
      SEL_TRANS = 2'd2
   } spr_sel_e;

endpackage

// ==== hdl/dmmu_spr_decode.sv ====
/* SPR side of the data MMU. Only group 1 is acked, in the second strobe cycle;
   master must hold address, data and we until ack, and never strobe other groups */
`timescale 1ns/1ps

module dmmu_spr_decode #(
   parameter int set_width = 6
) (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic [15:0]                          spr_addr_i,
   input  logic                                 spr_we_i,
   input  logic                                 spr_stb_i,
   input  logic [dmmu_pkg::operand_width-1:0]   spr_dat_i,
   input  logic [dmmu_pkg::operand_width-1:0]   match_word_i,
   input  logic [dmmu_pkg::operand_width-1:0]   trans_word_i,
   output dmmu_pkg::spr_sel_e                   spr_sel_o,
   output logic                                 spr_we_o,
   output logic [set_width-1:0]                 spr_index_o,
   output logic [dmmu_pkg::operand_width-1:0]   spr_wdat_o,
   output logic [dmmu_pkg::operand_width-1:0]   spr_dat_o,
   output logic                                 spr_ack_o
);

   logic               group_hit;      // Strobe into the MMU group
   logic               group_hit_r;
   logic               in_match;       // 0x0A00 .. 0x0A7F
   logic               in_trans;       // 0x0A80 .. 0x0AFF
   dmmu_pkg::spr_sel_e sel_r;          // Target of last cycle's strobe

   assign group_hit = spr_stb_i & (spr_addr_i[15:11] == dmmu_pkg::spr_group_dmmu);

   assign in_match = (spr_addr_i >= dmmu_pkg::spr_dtlbw0mr0_addr) &&
                     (spr_addr_i <  dmmu_pkg::spr_dtlbw0tr0_addr);
   assign in_trans = (spr_addr_i >= dmmu_pkg::spr_dtlbw0tr0_addr) &&
                     (spr_addr_i <  dmmu_pkg::spr_dtlbw1mr0_addr);

   // Target select, combinational so the RAM address switches this cycle
   always_comb begin
      if (!spr_stb_i)
         spr_sel_o = dmmu_pkg::SEL_NONE;
      else if (in_match)
         spr_sel_o = dmmu_pkg::SEL_MATCH;
      else if (in_trans)
         spr_sel_o = dmmu_pkg::SEL_TRANS;
      else
         spr_sel_o = dmmu_pkg::SEL_NONE;     // Rest of group 1 reads as zero
   end

   assign spr_we_o    = spr_we_i & (spr_sel_o != dmmu_pkg::SEL_NONE);
   assign spr_index_o = spr_addr_i[set_width-1:0];  // Entry number in range
   // Write data only toggles the RAM inputs on a real write
   assign spr_wdat_o  = spr_we_o ? spr_dat_i : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         group_hit_r <= 1'b0;
         sel_r       <= dmmu_pkg::SEL_NONE;
      end else begin
         group_hit_r <= group_hit;
         sel_r       <= spr_sel_o;               // Lines up with RAM read data
      end
   end

   // Drops together with the strobe
   assign spr_ack_o = group_hit_r & group_hit;

   // Read-back mux
   always_comb begin
      case (sel_r)
         dmmu_pkg::SEL_MATCH: spr_dat_o = match_word_i;
         dmmu_pkg::SEL_TRANS: spr_dat_o = trans_word_i;
         default:             spr_dat_o = '0;
      endcase
   end

endmodule

// ==== hdl/dmmu_top.sv ====
/* Data MMU, one-way direct-mapped TLB with 8 KB pages, results one cycle
   after virt_addr_i. set_width is 1..7; SPR strobes and lookups must not overlap */
`timescale 1ns/1ps

module dmmu_top #(
   parameter int set_width = 6          // TLB index bits
) (
   input  logic                                 clk,
   input  logic                                 rst,
   // Lookup
   input  logic [dmmu_pkg::operand_width-1:0]   virt_addr_i,
   input  logic [dmmu_pkg::operand_width-1:0]   virt_addr_match_i,
   input  logic                                 op_load_i,
   input  logic                                 op_store_i,
   input  logic                                 supervisor_mode_i,
   output logic [dmmu_pkg::operand_width-1:0]   phys_addr_o,
   output logic                                 cache_inhibit_o,
   output logic                                 tlb_miss_o,
   output logic                                 pagefault_o,
   // SPR bus
   input  logic [15:0]                          spr_addr_i,
   input  logic                                 spr_we_i,
   input  logic                                 spr_stb_i,
   input  logic [dmmu_pkg::operand_width-1:0]   spr_dat_i,
   output logic [dmmu_pkg::operand_width-1:0]   spr_dat_o,
   output logic                                 spr_ack_o
);

   dmmu_pkg::spr_sel_e                   spr_sel;
   logic                                 spr_we;
   logic [set_width-1:0]                 spr_index;
   logic [dmmu_pkg::operand_width-1:0]   spr_dat;       // Write data to RAMs
   logic [dmmu_pkg::operand_width-1:0]   match_word;
   logic [dmmu_pkg::operand_width-1:0]   trans_word;

   dmmu_spr_decode #(
      .set_width (set_width)
   ) u_spr_decode (
      .clk          (clk),
      .rst          (rst),
      .spr_addr_i   (spr_addr_i),
      .spr_we_i     (spr_we_i),
      .spr_stb_i    (spr_stb_i),
      .spr_dat_i    (spr_dat_i),
      .match_word_i (match_word),
      .trans_word_i (trans_word),
      .spr_sel_o    (spr_sel),
      .spr_we_o     (spr_we),
      .spr_index_o  (spr_index),
      .spr_wdat_o   (spr_dat),
      .spr_dat_o    (spr_dat_o),
      .spr_ack_o    (spr_ack_o)
   );

   dmmu_lookup #(
      .set_width (set_width)
   ) u_lookup (
      .clk               (clk),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .spr_sel_i         (spr_sel),
      .spr_we_i          (spr_we),
      .spr_index_i       (spr_index),
      .spr_dat_i         (spr_dat),
      .match_word_o      (match_word),
      .trans_word_o      (trans_word),
      .tlb_miss_o        (tlb_miss_o)
   );

   dmmu_check u_check (
      .trans_word_i      (trans_word),
      .virt_addr_match_i (virt_addr_match_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .supervisor_mode_i (supervisor_mode_i),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .pagefault_o       (pagefault_o)
   );

endmodule

// ==== hdl/tlb_ram.sv ====
/* Simple dual-port RAM, one clock, registered read data.
   No write bypass: a read of the address being written returns the old word */
`timescale 1ns/1ps

module tlb_ram #(
   parameter int addr_width = 6,
   parameter int data_width = 32
) (
   input  logic                  clk,
   input  logic [addr_width-1:0] raddr_i,
   input  logic [addr_width-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [data_width-1:0] din_i,
   output logic [data_width-1:0] dout_o
);

   logic [data_width-1:0] mem [0:(1 << addr_width)-1];   // Contents not cleared
   logic [data_width-1:0] dout_r;

   // Write port
   always_ff @(posedge clk) begin
      if (we_i)
         mem[waddr_i] <= din_i;
   end

   // Read port, sampled before this edge's write lands
   always_ff @(posedge clk) begin
      dout_r <= mem[raddr_i];
   end

   assign dout_o = dout_r;

endmodule

// ==== verification/dmmu_tb.sv ====
/* Directed tests for dmmu_top with set_width 6. SPR accesses and lookups never
   overlap, and every index is written before a lookup on it is checked */
`timescale 1ns/1ps

module dmmu_tb;

   localparam int set_width  = 6;
   localparam int entries    = 1 << set_width;
   localparam int pb         = dmmu_pkg::page_bits;
   localparam int max_cycles = 4000;   // Whole run needs about 300 cycles

   logic        clk;
   logic        rst;
   logic [31:0] virt_addr_i;
   logic [31:0] virt_addr_match_i;
   logic        op_load_i;
   logic        op_store_i;
   logic        supervisor_mode_i;
   logic [31:0] phys_addr_o;
   logic        cache_inhibit_o;
   logic        tlb_miss_o;
   logic        pagefault_o;
   logic [15:0] spr_addr_i;
   logic        spr_we_i;
   logic        spr_stb_i;
   logic [31:0] spr_dat_i;
   logic [31:0] spr_dat_o;
   logic        spr_ack_o;

   logic [31:0] match_sb [0:entries-1];   // Last word written per index
   logic [31:0] trans_sb [0:entries-1];
   int          cycles = 0;

   dmmu_top #(
      .set_width (set_width)
   ) u_dut (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .supervisor_mode_i (supervisor_mode_i),
      .phys_addr_o       (phys_addr_o),
      .cache_inhibit_o   (cache_inhibit_o),
      .tlb_miss_o        (tlb_miss_o),
      .pagefault_o       (pagefault_o),
      .spr_addr_i        (spr_addr_i),
      .spr_we_i          (spr_we_i),
      .spr_stb_i         (spr_stb_i),
      .spr_dat_i         (spr_dat_i),
      .spr_dat_o         (spr_dat_o),
      .spr_ack_o         (spr_ack_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;             // 100 MHz
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped");
   endtask

   // Watchdog
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles)
         fail_run($sformatf("timeout, run still going after %0d cycles", cycles));
   end

   task automatic check_word(input string name,
                             input logic [dmmu_pkg::operand_width-1:0] exp,
                             input logic [dmmu_pkg::operand_width-1:0] act);
      if (act !== exp)
         fail_run($sformatf("mismatch at %0t: %s expected %h actual %h",
                            $time, name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_run($sformatf("mismatch at %0t: %s expected %b actual %b",
                            $time, name, exp, act));
   endtask

   task automatic check_sel(input string name, input dmmu_pkg::spr_sel_e exp,
                            input dmmu_pkg::spr_sel_e act);
      if (act !== exp)
         fail_run($sformatf("mismatch at %0t: %s expected %s actual %s",
                            $time, name, exp.name(), act.name()));
   endtask

   // Which RAM an SPR address names by the range bounds
   function automatic dmmu_pkg::spr_sel_e target_of(input logic [15:0] addr);
      if (addr >= dmmu_pkg::spr_dtlbw0mr0_addr && addr < dmmu_pkg::spr_dtlbw0tr0_addr)
         return dmmu_pkg::SEL_MATCH;
      else if (addr >= dmmu_pkg::spr_dtlbw0tr0_addr && addr < dmmu_pkg::spr_dtlbw1mr0_addr)
         return dmmu_pkg::SEL_TRANS;
      else
         return dmmu_pkg::SEL_NONE;
   endfunction

   // Mode picks the permission pair and op picks read or write
   function automatic logic fault_of(input logic [31:0] tw, input logic ld, input logic st,
                                     input logic sup);
      logic rd_en;
      logic wr_en;
      rd_en = sup ? tw[dmmu_pkg::tr_sre_bit] : tw[dmmu_pkg::tr_ure_bit];
      wr_en = sup ? tw[dmmu_pkg::tr_swe_bit] : tw[dmmu_pkg::tr_uwe_bit];
      return (ld && !rd_en) || (st && !wr_en);
   endfunction

   // One strobe held until ack and then dropped
   task automatic spr_access(input logic [15:0] addr, input logic we, input logic [31:0] wdat,
                             output logic [31:0] rdat);
      int waits;
      @(posedge clk);
      #1;
      spr_addr_i = addr;
      spr_we_i   = we;
      spr_dat_i  = wdat;
      spr_stb_i  = 1'b1;
      @(negedge clk);
      check_bit("spr_ack_o", 1'b0, spr_ack_o);         // Never in the first cycle
      check_sel("u_dut.spr_sel", target_of(addr), u_dut.spr_sel);
      waits = 0;
      do begin
         @(negedge clk);
         waits++;
      end while (!spr_ack_o && waits < 8);            // Bounded wait
      if (!spr_ack_o)
         fail_run($sformatf("no ack for SPR address %h within %0d cycles", addr, waits + 1));
      else if (waits != 1)
         fail_run($sformatf("ack for SPR address %h came in strobe cycle %0d", addr, waits + 1));
      rdat = spr_dat_o;                                // Valid while ack is high
      @(posedge clk);
      #1;
      spr_stb_i = 1'b0;
      spr_we_i  = 1'b0;
      @(negedge clk);
      check_bit("spr_ack_o", 1'b0, spr_ack_o);         // Falls with the strobe
   endtask

   task automatic spr_write(input logic [15:0] addr, input logic [31:0] wdat);
      logic [31:0] unused_rd;
      spr_access(addr, 1'b1, wdat, unused_rd);
   endtask

   task automatic spr_read(input logic [15:0] addr, output logic [31:0] rdat);
      spr_access(addr, 1'b0, 32'h0, rdat);
   endtask

   task automatic write_match(input int idx, input logic [31:0] word);
      spr_write(dmmu_pkg::spr_dtlbw0mr0_addr + 16'(idx), word);
      match_sb[idx] = word;
   endtask

   task automatic write_trans(input int idx, input logic [31:0] word);
      spr_write(dmmu_pkg::spr_dtlbw0tr0_addr + 16'(idx), word);
      trans_sb[idx] = word;
   endtask

   task automatic verify_match(input int idx);
      logic [31:0] rd;
      spr_read(dmmu_pkg::spr_dtlbw0mr0_addr + 16'(idx), rd);
      check_word($sformatf("spr_dat_o match[%0d]", idx), match_sb[idx], rd);
   endtask

   task automatic verify_trans(input int idx);
      logic [31:0] rd;
      spr_read(dmmu_pkg::spr_dtlbw0tr0_addr + 16'(idx), rd);
      check_word($sformatf("spr_dat_o trans[%0d]", idx), trans_sb[idx], rd);
   endtask

   task automatic present_addr(input logic [31:0] va);
      @(posedge clk);
      #1;
      virt_addr_i = va;
   endtask

   // va must sit on virt_addr_i for one edge and next_va goes out with it
   task automatic lookup(input logic [31:0] va, input logic [31:0] next_va,
                         input logic ld, input logic st, input logic sup);
      logic [31:0] mw;
      logic [31:0] tw;
      int          idx;
      @(posedge clk);
      #1;
      virt_addr_match_i = va;
      virt_addr_i       = next_va;
      op_load_i         = ld;
      op_store_i        = st;
      supervisor_mode_i = sup;
      @(negedge clk);
      idx = int'(va[pb +: set_width]);
      mw  = match_sb[idx];
      tw  = trans_sb[idx];
      check_bit("tlb_miss_o", (mw[31:pb] != va[31:pb]) || !mw[dmmu_pkg::mr_valid_bit],
                tlb_miss_o);
      check_word("phys_addr_o", {tw[31:pb], va[pb-1:0]}, phys_addr_o);
      check_bit("cache_inhibit_o", tw[dmmu_pkg::tr_ci_bit], cache_inhibit_o);
      check_bit("pagefault_o", fault_of(tw, ld, st, sup), pagefault_o);
   endtask

   task automatic reset_values;
      @(negedge clk);
      check_bit("spr_ack_o", 1'b0, spr_ack_o);
      check_word("spr_dat_o", 32'h0, spr_dat_o);
   endtask

   task automatic random_readback;
      int          idx_q[$];
      bit          trans_q[$];                          // 1 for translate RAM
      int          idx;
      logic [31:0] rd;
      for (int i = 0; i < 12; i++) begin
         idx = $urandom_range(entries - 1, 0);
         trans_q.push_back($urandom_range(1, 0) == 1);
         idx_q.push_back(idx);
         if (trans_q[i])
            write_trans(idx, $urandom);
         else
            write_match(idx, $urandom);
      end
      foreach (idx_q[i]) begin
         if (trans_q[i])
            verify_trans(idx_q[i]);
         else
            verify_match(idx_q[i]);
      end
      spr_read(16'h0B40, rd);                            // Group 1 address outside both ranges
      check_word("spr_dat_o at 0B40", 32'h0, rd);
   endtask

   task automatic hit_lookups;
      logic [31:0] va [0:2];
      int          idx;
      for (int k = 0; k < 3; k++) begin
         idx = k * 5 + 3;                               // Distinct sets
         va[k] = $urandom;
         va[k][pb +: set_width] = 6'(idx);
         write_match(idx, {va[k][31:pb], 12'($urandom), 1'b1});
         write_trans(idx, $urandom);
      end
      present_addr(va[0]);
      lookup(va[0], va[1], 1'b0, 1'b0, 1'b0);           // Next one already addressed
      check_bit("tlb_miss_o hit", 1'b0, tlb_miss_o);
      lookup(va[1], va[2], 1'b0, 1'b0, 1'b1);
      check_bit("tlb_miss_o hit", 1'b0, tlb_miss_o);
      lookup(va[2], va[2], 1'b0, 1'b0, 1'b0);
      check_bit("tlb_miss_o hit", 1'b0, tlb_miss_o);
   endtask

   task automatic miss_lookups;
      logic [31:0] va;
      va = $urandom;
      va[pb +: set_width] = 6'(20);
      write_match(20, {va[31:pb] ^ 19'h40000, 13'h1}); // VPN off in bit 31
      write_trans(20, $urandom);
      present_addr(va);
      lookup(va, va, 1'b0, 1'b0, 1'b0);
      check_bit("tlb_miss_o vpn", 1'b1, tlb_miss_o);
      write_match(20, {va[31:pb], 13'h0});              // Right VPN but not valid
      present_addr(va);
      lookup(va, va, 1'b0, 1'b0, 1'b0);
      check_bit("tlb_miss_o invalid", 1'b1, tlb_miss_o);
   endtask

   // All 16 permission patterns x mode x {none, load, store}
   task automatic fault_patterns;
      logic [31:0] va;
      logic [31:0] tw;
      va = $urandom;
      va[pb +: set_width] = 6'(33);
      write_match(33, {va[31:pb], 13'h1});
      for (int perm = 0; perm < 16; perm++) begin
         tw = $urandom;
         tw[dmmu_pkg::tr_ure_bit] = perm[0];
         tw[dmmu_pkg::tr_uwe_bit] = perm[1];
         tw[dmmu_pkg::tr_sre_bit] = perm[2];
         tw[dmmu_pkg::tr_swe_bit] = perm[3];
         write_trans(33, tw);
         present_addr(va);                              // SPR strobe stole the RAM address
         for (int sup = 0; sup < 2; sup++)
            for (int op = 0; op < 3; op++)
               lookup(va, va, op == 1, op == 2, sup[0]);
      end
   endtask

   task automatic match_isolation;
      write_match(45, $urandom);
      write_trans(45, $urandom);
      verify_match(45);
      write_trans(45, ~trans_sb[45]);
      verify_match(45);                                 // Match side untouched
      verify_trans(45);
   endtask

   initial begin
      void'($urandom(32'h40668577));
      rst               = 1'b1;
      virt_addr_i       = 32'h0;
      virt_addr_match_i = 32'h0;
      op_load_i         = 1'b0;
      op_store_i        = 1'b0;
      supervisor_mode_i = 1'b0;
      spr_addr_i        = 16'h0;
      spr_we_i          = 1'b0;
      spr_stb_i         = 1'b0;
      spr_dat_i         = 32'h0;
      repeat (4) @(posedge clk);
      #1;
      rst = 1'b0;
      reset_values();
      random_readback();
      hit_lookups();
      miss_lookups();
      fault_patterns();
      match_isolation();
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule
